/* verilog.f */
+incdir+testbench
logic/dsi_pkg.sv
logic/link_pkg.sv
logic/header_decode.sv
logic/payload_execute.sv
logic/lane_word_result.sv
logic/packet_assembler_top.sv
testbench/tb_packet_assembler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the packet assembler testbench with verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_packet_assembler \
        -f verilog.f -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim; then
    echo "simulation returned a failing status"
    exit 1
fi

echo "simulation returned a passing status"
exit 0

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

link_pkg::lane_word_t exp_q[$];         // lane words the DUT still has to send
logic [7:0]           packet_bytes[$];  // byte stream of the packet being modelled
int                   errors_expected;
int                   errors_seen;
logic                 mode_expected;

function automatic dsi_pkg::packet_kind_e kind_of(input dsi_pkg::data_id_t id);
    if (id[3:0] == 4'h0 || id[3:0] == 4'hf)
        return dsi_pkg::KIND_RESERVED;
    else if (id[3:0] == 4'h9)
        return dsi_pkg::KIND_LONG;
    return dsi_pkg::KIND_SHORT;
endfunction

// dsi header hamming code written out bit by bit
function automatic dsi_pkg::ecc_t ecc_of(input logic [23:0] d);
    dsi_pkg::ecc_t e;
    e = '0;
    e[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
    e[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
    e[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
    e[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
    e[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
    e[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
    return e;
endfunction

function automatic dsi_pkg::crc_t crc_step(input dsi_pkg::crc_t crc, input logic [7:0] data);
    logic fb;
    for (int i = 0; i < 8; i++)
    begin
        fb  = crc[0] ^ data[i];  // lsb of the byte enters first
        crc = crc >> 1;
        if (fb)
            crc = crc ^ dsi_pkg::CRC_POLY_REFLECTED;
    end
    return crc;
endfunction

// packs the modelled byte stream densely into lane words
task automatic expect_bytes();
    link_pkg::lane_word_t w;
    int                   n;
    while (packet_bytes.size() > 0)
    begin
        w = '0;
        n = 0;
        while (n < 4 && packet_bytes.size() > 0)
        begin
            w.data[8*n +: 8] = packet_bytes.pop_front();
            w.strb[n]        = 1'b1;
            n++;
        end
        w.last = packet_bytes.size() == 0;
        exp_q.push_back(w);
    end
endtask

task automatic compare_word(input link_pkg::lane_word_t got, input link_pkg::lane_word_t exp);
    if (got !== exp)
    begin
        $display("error: %0d ns iface_write_data/strb/last got %h/%b/%b expected %h/%b/%b",
                 $time, got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
        fail_run("lane word differs from the model");
    end
endtask

task automatic compare_error(input int seen, input int expected);
    if (seen > expected)
    begin
        $display("error: %0d ns packet_error pulse count got %0d expected %0d",
                 $time, seen, expected);
        fail_run("packet_error pulsed without a reserved header");
    end
endtask

task automatic compare_mode(input logic got, input logic expected);
    if (got !== expected)
    begin
        $display("error: %0d ns iface_lpm_en got %b expected %b", $time, got, expected);
        fail_run("transmission mode changed inside a packet");
    end
endtask

`endif

/* testbench/tb_packet_assembler.sv */
`timescale 1ns/1ps

module tb_packet_assembler;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int GROUPS         = 40;

    logic        clk_sys;
    logic        reset_block_read_data_hs;
    logic [31:0] usr_fifo_data;
    logic        usr_fifo_empty;
    logic        usr_fifo_read;
    logic        user_cmd_transmission_mode;
    logic [31:0] iface_write_data;
    logic [3:0]  iface_write_strb;
    logic        iface_write_rqst;
    logic        iface_last_word;
    logic        iface_lpm_en;
    logic        iface_data_rqst;
    logic        packet_error;

    integer               seed;
    logic [31:0]          fifo_q[$];  // show-ahead fifo contents, head is on usr_fifo_data
    logic                 pop_seen;
    link_pkg::lane_word_t got_word;

    task automatic fail_run(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    `include "tb_model.svh"

    packet_assembler_top dut0 (.*);

    initial clk_sys = 1'b0;
    always #10 clk_sys = ~clk_sys;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // pushes one packet into the fifo and its lane words into the model
    task automatic send_packet(input dsi_pkg::data_id_t id, input dsi_pkg::word_count_t wc);
        logic [31:0]   word;
        dsi_pkg::crc_t crc;
        fifo_q.push_back({8'(rand_below(256)), wc, id});  // byte 3 must be overwritten
        if (kind_of(id) == dsi_pkg::KIND_RESERVED)
        begin
            errors_expected++;
            return;
        end
        packet_bytes.push_back(id);
        packet_bytes.push_back(wc[7:0]);
        packet_bytes.push_back(wc[15:8]);
        packet_bytes.push_back(ecc_of({wc, id}));
        if (kind_of(id) == dsi_pkg::KIND_LONG)
        begin
            crc = dsi_pkg::CRC_SEED;
            for (int w = 0; w < (int'(wc) + 3) / 4; w++)
            begin
                word = $random(seed);
                fifo_q.push_back(word);
                for (int b = 0; b < 4; b++)
                begin
                    if (4 * w + b < int'(wc))
                    begin
                        packet_bytes.push_back(word[8*b +: 8]);
                        crc = crc_step(crc, word[8*b +: 8]);
                    end
                end
            end
            packet_bytes.push_back(crc[7:0]);
            packet_bytes.push_back(crc[15:8]);
        end
        expect_bytes();
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || fifo_q.size() != 0 || errors_seen != errors_expected)
        begin
            @(posedge clk_sys);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                fail_run("timeout: packets did not drain from the assembler");
        end
    endtask

    // fifo and lanes side, driven just after the rising edge
    initial
    begin
        usr_fifo_data   = 32'h0;
        usr_fifo_empty  = 1'b1;
        iface_data_rqst = 1'b0;
        forever
        begin
            @(posedge clk_sys);
            #2;
            if (pop_seen && fifo_q.size() > 0)
                void'(fifo_q.pop_front());
            iface_data_rqst = rand_below(2) == 0;  // lanes busy about half the time
            usr_fifo_empty  = fifo_q.size() == 0 || rand_below(4) == 0;
            usr_fifo_data   = (fifo_q.size() > 0) ? fifo_q[0] : 32'h0;
        end
    end

    // outputs are stable mid cycle, so they are sampled on the falling edge
    initial
    begin
        pop_seen    = 1'b0;
        errors_seen = 0;
        forever
        begin
            @(negedge clk_sys);
            pop_seen = usr_fifo_read && !reset_block_read_data_hs;
            if (!reset_block_read_data_hs && packet_error)
            begin
                errors_seen++;
                compare_error(errors_seen, errors_expected);
            end
            if (!reset_block_read_data_hs && iface_write_rqst && iface_data_rqst)
            begin
                if (exp_q.size() == 0)
                    fail_run("a lane word was sent when none was expected");
                got_word = {iface_write_data, iface_write_strb, iface_last_word};
                compare_word(got_word, exp_q.pop_front());
                compare_mode(iface_lpm_en, mode_expected);
            end
        end
    end

    initial
    begin
        int                   packets;
        int                   choice;
        logic [3:0]           nibble;
        dsi_pkg::word_count_t wc;
        seed                       = 32'hf7f1_f0f2;
        reset_block_read_data_hs   = 1'b1;
        user_cmd_transmission_mode = 1'b0;
        errors_expected            = 0;
        mode_expected              = 1'b0;
        repeat (10) @(posedge clk_sys);
        #2;
        reset_block_read_data_hs = 1'b0;
        for (int g = 0; g < GROUPS; g++)
        begin
            @(posedge clk_sys);
            #1;
            mode_expected = rand_below(2) == 1;
            #1;
            user_cmd_transmission_mode = mode_expected;  // pipeline is empty here
            @(posedge clk_sys);
            #1;
            packets = 1 + rand_below(4);
            for (int p = 0; p < packets; p++)
            begin
                choice = rand_below(8);
                wc     = 16'(rand_below(65536));  // parameters of a short packet
                if (choice == 0)
                    nibble = (rand_below(2) == 0) ? 4'h0 : 4'hf;
                else if (choice < 5)
                begin
                    nibble = 4'h9;
                    wc     = (choice == 1) ? 16'd0 : 16'(1 + rand_below(40));
                end
                else
                begin
                    nibble = 4'(1 + rand_below(13));
                    if (nibble >= 4'h9)
                        nibble = nibble + 4'h1;  // skip the long type
                end
                send_packet({4'(rand_below(16)), nibble}, wc);
            end
            wait_drained();
        end
        @(negedge clk_sys);
        #1;
        if (!iface_write_rqst && !packet_error)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
            fail_run("the assembler is still busy after the last packet drained");
    end

endmodule

/* logic/packet_assembler_top.sv */
`timescale 1ns/1ps

module packet_assembler_top
(
    input  logic        clk_sys,
    input  logic        reset_block_read_data_hs,
    input  logic [31:0] usr_fifo_data,
    input  logic        usr_fifo_empty,
    output logic        usr_fifo_read,
    input  logic        user_cmd_transmission_mode,  // 0 sends user packets in hs, 1 in lp
    output logic [31:0] iface_write_data,
    output logic [3:0]  iface_write_strb,
    output logic        iface_write_rqst,
    output logic        iface_last_word,
    output logic        iface_lpm_en,
    input  logic        iface_data_rqst,
    output logic        packet_error
);

    link_pkg::fifo_beat_t decode_beat;
    logic                 decode_valid;
    logic                 decode_ready;
    link_pkg::lane_beat_t exec_beat;
    logic                 exec_valid;
    logic                 exec_ready;

    header_decode decode0
    (
        .clk_sys                  (clk_sys),
        .reset_block_read_data_hs (reset_block_read_data_hs),
        .usr_fifo_data            (usr_fifo_data),
        .usr_fifo_empty           (usr_fifo_empty),
        .usr_fifo_read            (usr_fifo_read),
        .decode_beat              (decode_beat),
        .decode_valid             (decode_valid),
        .decode_ready             (decode_ready),
        .packet_error             (packet_error)
    );

    payload_execute execute0
    (
        .clk_sys                  (clk_sys),
        .reset_block_read_data_hs (reset_block_read_data_hs),
        .decode_beat              (decode_beat),
        .decode_valid             (decode_valid),
        .decode_ready             (decode_ready),
        .exec_beat                (exec_beat),
        .exec_valid               (exec_valid),
        .exec_ready               (exec_ready)
    );

    lane_word_result result0
    (
        .clk_sys                    (clk_sys),
        .reset_block_read_data_hs   (reset_block_read_data_hs),
        .exec_beat                  (exec_beat),
        .exec_valid                 (exec_valid),
        .exec_ready                 (exec_ready),
        .user_cmd_transmission_mode (user_cmd_transmission_mode),
        .iface_write_data           (iface_write_data),
        .iface_write_strb           (iface_write_strb),
        .iface_write_rqst           (iface_write_rqst),
        .iface_last_word            (iface_last_word),
        .iface_lpm_en               (iface_lpm_en),
        .iface_data_rqst            (iface_data_rqst)
    );

endmodule

/* logic/lane_word_result.sv */
`timescale 1ns/1ps

module lane_word_result
(
    input  logic                 clk_sys,
    input  logic                 reset_block_read_data_hs,
    input  link_pkg::lane_beat_t exec_beat,
    input  logic                 exec_valid,
    output logic                 exec_ready,
    input  logic                 user_cmd_transmission_mode,
    output logic [31:0]          iface_write_data,
    output logic [3:0]           iface_write_strb,
    output logic                 iface_write_rqst,
    output logic                 iface_last_word,
    output logic                 iface_lpm_en,  // 0 for hs, 1 for lp
    input  logic                 iface_data_rqst
);

    link_pkg::lane_word_t  out_word;
    link_pkg::lane_word_t  next_word;
    link_pkg::byte_count_t offset;         // bytes already waiting in the temp buffer
    link_pkg::byte_count_t total;
    logic [31:0]           temp_buffer;
    logic [63:0]           combined;
    logic                  flush_pending;  // tail bytes of a packet still need their own word
    logic                  in_packet;
    logic                  slot_free;
    logic                  word_xfer;
    logic                  beat_xfer;
    logic                  emit_beat;
    logic                  emit_flush;

    function automatic logic [3:0] strobe_of(input link_pkg::byte_count_t count);
        case (count)
            3'd0:    return 4'b0000;
            3'd1:    return 4'b0001;
            3'd2:    return 4'b0011;
            3'd3:    return 4'b0111;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] byte_mask(input link_pkg::byte_count_t count);
        logic [3:0] strb;
        strb = strobe_of(count);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    assign word_xfer  = iface_write_rqst && iface_data_rqst;
    assign slot_free  = !iface_write_rqst || iface_data_rqst;
    assign exec_ready = !flush_pending && slot_free && !iface_last_word;  // one packet per burst
    assign beat_xfer  = exec_valid && exec_ready;

    // new bytes land right above the ones kept from earlier beats
    assign total    = offset + exec_beat.bytes;
    assign combined = {32'h0, temp_buffer & byte_mask(offset)} |
                      ({32'h0, exec_beat.data & byte_mask(exec_beat.bytes)} << {offset, 3'b000});

    assign emit_beat  = beat_xfer && (total >= link_pkg::WORD_BYTES || exec_beat.end_of_packet);
    assign emit_flush = flush_pending && slot_free;

    always_comb
    begin
        next_word.data = combined[31:0];
        next_word.strb = strobe_of(total);
        next_word.last = exec_beat.end_of_packet && total <= link_pkg::WORD_BYTES;
        if (flush_pending)
        begin
            next_word.data = temp_buffer & byte_mask(offset);
            next_word.strb = strobe_of(offset);
            next_word.last = 1'b1;
        end
    end

    assign iface_write_data = out_word.data;
    assign iface_write_strb = out_word.strb;
    assign iface_last_word  = iface_write_rqst && out_word.last;

    always_ff @(posedge clk_sys)
    begin
        if (emit_beat || emit_flush)
            out_word <= next_word;
        if (beat_xfer)
            temp_buffer <= (total >= link_pkg::WORD_BYTES) ? combined[63:32] : combined[31:0];
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_block_read_data_hs)
        begin
            offset           <= '0;
            flush_pending    <= 1'b0;
            iface_write_rqst <= 1'b0;
            in_packet        <= 1'b0;
            iface_lpm_en     <= 1'b0;
        end
        else
        begin
            if (emit_beat || emit_flush)
                iface_write_rqst <= 1'b1;
            else if (word_xfer)
                iface_write_rqst <= 1'b0;

            if (emit_flush)
            begin
                flush_pending <= 1'b0;
                offset        <= '0;
            end
            else if (beat_xfer && total < link_pkg::WORD_BYTES)
                offset <= exec_beat.end_of_packet ? '0 : total;
            else if (beat_xfer)
            begin
                offset        <= total - link_pkg::WORD_BYTES;
                flush_pending <= exec_beat.end_of_packet && total > link_pkg::WORD_BYTES;
            end

            if (word_xfer && iface_last_word)
                in_packet <= 1'b0;
            if (beat_xfer)
                in_packet <= 1'b1;

            // mode is sampled only between packets so it stays stable across a burst
            if (!in_packet && !exec_valid)
                iface_lpm_en <= user_cmd_transmission_mode;
        end
    end

endmodule

/* logic/payload_execute.sv */
`timescale 1ns/1ps

module payload_execute
(
    input  logic                 clk_sys,
    input  logic                 reset_block_read_data_hs,
    input  link_pkg::fifo_beat_t decode_beat,
    input  logic                 decode_valid,
    output logic                 decode_ready,
    output link_pkg::lane_beat_t exec_beat,
    output logic                 exec_valid,
    input  logic                 exec_ready
);

    typedef enum logic
    {
        EXE_PASS,
        EXE_CRC
    } exe_state_e;

    exe_state_e           exe_state;
    dsi_pkg::crc_t        crc_reg;
    dsi_pkg::crc_t        crc_next;
    link_pkg::lane_beat_t next_beat;
    logic                 slot_free;
    logic                 beat_in;
    logic                 crc_out;

    // one payload byte folded in lsb first
    function automatic dsi_pkg::crc_t crc_byte(input dsi_pkg::crc_t crc, input logic [7:0] data);
        dsi_pkg::crc_t c;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ dsi_pkg::CRC_POLY_REFLECTED;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    assign slot_free    = !exec_valid || exec_ready;
    assign decode_ready = slot_free && exe_state == EXE_PASS;  // stalled while the footer goes out
    assign beat_in      = decode_valid && decode_ready;
    assign crc_out      = slot_free && exe_state == EXE_CRC;

    always_comb
    begin
        crc_next = crc_reg;
        for (int i = 0; i < int'(link_pkg::WORD_BYTES); i++)
        begin
            if (i < int'(decode_beat.bytes))
                crc_next = crc_byte(crc_next, decode_beat.data[8*i +: 8]);
        end
    end

    always_comb
    begin
        next_beat.data          = decode_beat.data;
        next_beat.bytes         = decode_beat.bytes;
        next_beat.end_of_packet = decode_beat.kind == link_pkg::BEAT_HEADER_SHORT;
        if (exe_state == EXE_CRC)
        begin
            next_beat.data          = {16'h0000, crc_reg};  // low byte goes out first
            next_beat.bytes         = link_pkg::byte_count_t'(dsi_pkg::CRC_BYTES);
            next_beat.end_of_packet = 1'b1;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (beat_in || crc_out)
            exec_beat <= next_beat;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_block_read_data_hs)
        begin
            exe_state  <= EXE_PASS;
            exec_valid <= 1'b0;
            crc_reg    <= dsi_pkg::CRC_SEED;
        end
        else
        begin
            if (beat_in || crc_out)
                exec_valid <= 1'b1;
            else if (exec_ready)
                exec_valid <= 1'b0;
            if (crc_out)
                exe_state <= EXE_PASS;
            else if (beat_in)
            begin
                if (decode_beat.kind == link_pkg::BEAT_HEADER_LONG)
                    crc_reg <= dsi_pkg::CRC_SEED;  // a new long packet restarts the checksum
                else if (decode_beat.kind == link_pkg::BEAT_PAYLOAD)
                    crc_reg <= crc_next;
                if (decode_beat.last && decode_beat.kind != link_pkg::BEAT_HEADER_SHORT)
                    exe_state <= EXE_CRC;
            end
        end
    end

endmodule

/* logic/header_decode.sv */
`timescale 1ns/1ps

module header_decode
(
    input  logic                 clk_sys,
    input  logic                 reset_block_read_data_hs,
    input  logic [31:0]          usr_fifo_data,
    input  logic                 usr_fifo_empty,
    output logic                 usr_fifo_read,
    output link_pkg::fifo_beat_t decode_beat,
    output logic                 decode_valid,
    input  logic                 decode_ready,
    output logic                 packet_error
);

    typedef enum logic
    {
        DEC_HEADER,
        DEC_PAYLOAD
    } dec_state_e;

    dec_state_e             dec_state;
    dsi_pkg::word_count_t   bytes_left;     // payload bytes still to be read from the fifo
    dsi_pkg::word_count_t   word_count;
    dsi_pkg::packet_kind_e  header_kind;
    dsi_pkg::ecc_t          ecc;
    link_pkg::fifo_beat_t   next_beat;
    logic                   slot_free;
    logic                   reserved_hdr;
    logic                   beat_load;
    logic                   payload_last;

    function automatic dsi_pkg::packet_kind_e classify(input dsi_pkg::data_id_t data_id);
        if (data_id[3:0] == dsi_pkg::DT_NIBBLE_RESERVED_LO ||
            data_id[3:0] == dsi_pkg::DT_NIBBLE_RESERVED_HI)
            return dsi_pkg::KIND_RESERVED;
        if (data_id[3:0] == dsi_pkg::DT_NIBBLE_LONG)
            return dsi_pkg::KIND_LONG;
        return dsi_pkg::KIND_SHORT;
    endfunction

    // hamming parity over data identifier and word count, top two bits stay zero
    function automatic dsi_pkg::ecc_t header_ecc(input logic [23:0] header);
        dsi_pkg::ecc_t result;
        result = '0;
        for (int i = 0; i < dsi_pkg::ECC_USED_BITS; i++)
        begin
            result[i] = ^(header & dsi_pkg::ECC_MASKS[i]);
        end
        return result;
    endfunction

    assign word_count   = usr_fifo_data[23:8];
    assign header_kind  = classify(usr_fifo_data[7:0]);
    assign ecc          = header_ecc(usr_fifo_data[23:0]);
    assign payload_last = bytes_left <= dsi_pkg::word_count_t'(link_pkg::WORD_BYTES);

    assign slot_free     = !decode_valid || decode_ready;
    assign usr_fifo_read = !usr_fifo_empty && slot_free;  // show-ahead fifo, data is already valid
    assign reserved_hdr  = dec_state == DEC_HEADER && header_kind == dsi_pkg::KIND_RESERVED;
    assign beat_load     = usr_fifo_read && !reserved_hdr;

    always_comb
    begin
        next_beat = '0;
        if (dec_state == DEC_HEADER)
        begin
            next_beat.kind  = (header_kind == dsi_pkg::KIND_LONG) ? link_pkg::BEAT_HEADER_LONG
                                                                   : link_pkg::BEAT_HEADER_SHORT;
            next_beat.data  = {ecc, usr_fifo_data[23:0]};  // byte 3 from the user is replaced
            next_beat.bytes = link_pkg::WORD_BYTES;
            next_beat.last  = header_kind == dsi_pkg::KIND_LONG && word_count == '0;
        end
        else
        begin
            next_beat.kind  = link_pkg::BEAT_PAYLOAD;
            next_beat.data  = usr_fifo_data;
            next_beat.bytes = payload_last ? link_pkg::byte_count_t'(bytes_left)
                                           : link_pkg::WORD_BYTES;
            next_beat.last  = payload_last;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (beat_load)
            decode_beat <= next_beat;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_block_read_data_hs)
        begin
            dec_state    <= DEC_HEADER;
            bytes_left   <= '0;
            decode_valid <= 1'b0;
            packet_error <= 1'b0;
        end
        else
        begin
            packet_error <= usr_fifo_read && reserved_hdr;  // the reserved word is dropped
            if (decode_ready)
                decode_valid <= 1'b0;
            if (beat_load)
                decode_valid <= 1'b1;
            if (usr_fifo_read && dec_state == DEC_HEADER)
            begin
                if (header_kind == dsi_pkg::KIND_LONG && word_count != '0)
                begin
                    dec_state  <= DEC_PAYLOAD;
                    bytes_left <= word_count;
                end
            end
            else if (usr_fifo_read)
            begin
                bytes_left <= bytes_left - dsi_pkg::word_count_t'(link_pkg::WORD_BYTES);
                if (payload_last)
                    dec_state <= DEC_HEADER;
            end
        end
    end

endmodule

/* logic/link_pkg.sv */
package link_pkg;

    typedef logic [2:0] byte_count_t;  // number of valid bytes, 0 to 4

    localparam byte_count_t WORD_BYTES = 3'd4;

    typedef enum logic [1:0]
    {
        BEAT_HEADER_SHORT,
        BEAT_HEADER_LONG,
        BEAT_PAYLOAD
    } beat_kind_e;

    typedef struct packed
    {
        beat_kind_e  kind;
        logic [31:0] data;
        byte_count_t bytes;
        logic        last;  // final payload beat of a long packet
    } fifo_beat_t;

    typedef struct packed
    {
        logic [31:0] data;
        byte_count_t bytes;
        logic        end_of_packet;
    } lane_beat_t;

    typedef struct packed
    {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } lane_word_t;

endpackage

/* logic/dsi_pkg.sv */
package dsi_pkg;

    typedef logic [7:0]  data_id_t;     // virtual channel in [7:6], data type in [5:0]
    typedef logic [15:0] word_count_t;  // payload bytes of a long packet
    typedef logic [7:0]  ecc_t;         // only the low six bits carry parity
    typedef logic [15:0] crc_t;

    typedef enum logic [1:0]
    {
        KIND_SHORT,
        KIND_LONG,
        KIND_RESERVED
    } packet_kind_e;

    // the low nibble of the data identifier selects the packet kind
    localparam logic [3:0] DT_NIBBLE_LONG        = 4'h9;
    localparam logic [3:0] DT_NIBBLE_RESERVED_LO = 4'h0;
    localparam logic [3:0] DT_NIBBLE_RESERVED_HI = 4'hf;

    localparam int ECC_USED_BITS = 6;

    // each parity bit is the xor of the header bits selected by its mask, p5 first
    localparam logic [ECC_USED_BITS-1:0][23:0] ECC_MASKS =
    {
        24'hEFFC00,
        24'hDF03F0,
        24'hB8E38E,
        24'h749A6D,
        24'hF2555B,
        24'hF12CB7
    };

    localparam crc_t CRC_SEED           = 16'hffff;
    localparam crc_t CRC_POLY_REFLECTED = 16'h8408;  // x^16+x^12+x^5+1 bit reversed
    localparam int   CRC_BYTES          = 2;

endpackage
